/* src/ising_pkg.sv */
// ==============================
// ising_pkg
// default sizes of the energy evaluator and the
// decode of the h scaling code into a shift
// ==============================
`default_nettype none

package ising_pkg;

    // defaults of the top level parameters
    localparam int DEF_BITJ             = 4;    // J weight width
    localparam int DEF_BITH             = 4;    // h bias width
    localparam int DEF_DATASPIN         = 16;   // spins per job
    localparam int DEF_LANES            = 4;    // DATASPIN must be a multiple
    localparam int DEF_SCALING_BIT      = 5;    // width of the scaling code
    localparam int DEF_ENERGY_TOTAL_BIT = 16;   // result wraps to this

    // scaling code to bias shift
    // only 1, 2, 4, 8 and 16 scale; any other code acts as x1
    function automatic int unsigned scale_shift(input int unsigned code);
        int unsigned shift;
        case (code)
            1:       shift = 0;
            2:       shift = 1;
            4:       shift = 2;
            8:       shift = 3;
            16:      shift = 4;
            default: shift = 0;   // 0, 3, 31 ... behave like 1
        endcase
        return shift;
    endfunction

endpackage

`default_nettype wire

/* src/adder_tree.sv */
// ==============================
// adder_tree
// combinational pairwise adder tree that reduces N signed
// inputs to one sum sign-extended or truncated to SUMW
// ==============================
`timescale 1ns/1ns
`default_nettype none

module adder_tree #(
    parameter int N     = 4,
    parameter int DATAW = 8,
    parameter int SUMW  = 16
) (
    input  logic signed [N-1:0][DATAW-1:0] data_i,   // packed signed operands
    output logic signed [SUMW-1:0]         sum_o
);

    localparam int LEVELS = (N > 1) ? $clog2(N) : 0;
    localparam int TREEW  = DATAW + LEVELS;   // one extra bit per level

    // node[l][i] is entry i of level l and level 0 holds the inputs
    logic [LEVELS:0][N-1:0][TREEW-1:0] node;

    // live entries on a level
    function automatic int level_cnt(input int lvl);
        return (N + (1 << lvl) - 1) >> lvl;
    endfunction

    genvar l, i;

    generate
        for (i = 0; i < N; i++) begin : g_leaf
            assign node[0][i] = TREEW'($signed(data_i[i]));   // sign extend
        end

        for (l = 1; l <= LEVELS; l++) begin : g_level
            for (i = 0; i < N; i++) begin : g_node
                if (2*i + 1 < level_cnt(l-1)) begin : g_add
                    assign node[l][i] = $signed(node[l-1][2*i]) + $signed(node[l-1][2*i+1]);
                end else if (2*i < level_cnt(l-1)) begin : g_pass
                    assign node[l][i] = node[l-1][2*i];   // odd leftover
                end else begin : g_idle
                    assign node[l][i] = '0;               // slot past the level end
                end
            end
        end
    endgenerate

    // root widened or wrapped to the requested width
    assign sum_o = SUMW'($signed(node[LEVELS][0]));

endmodule

`default_nettype wire

/* src/partial_energy_calc.sv */
// ==============================
// partial_energy_calc
// one lane computing the partial energy of the masked spin
// combinational sigma_i * (sum_j J_ij*sigma_j + h_i*k)
// ==============================
`timescale 1ns/1ns
`default_nettype none

module partial_energy_calc #(
    parameter int BITJ             = ising_pkg::DEF_BITJ,
    parameter int BITH             = ising_pkg::DEF_BITH,
    parameter int DATASPIN         = ising_pkg::DEF_DATASPIN,
    parameter int SCALING_BIT      = ising_pkg::DEF_SCALING_BIT,
    parameter int ENERGY_TOTAL_BIT = ising_pkg::DEF_ENERGY_TOTAL_BIT
) (
    input  logic [DATASPIN-1:0]               spin_i,        // 1 -> +1, 0 -> -1
    input  logic [DATASPIN-1:0]               spin_mask_i,   // one-hot own spin
    input  logic [DATASPIN*BITJ-1:0]          weight_i,      // J row of own spin
    input  logic signed [BITH-1:0]            hbias_i,
    input  logic [SCALING_BIT-1:0]            hscaling_i,
    output logic signed [ENERGY_TOTAL_BIT-1:0] energy_o
);

    // term width fits h shifted by up to 4 or a negated J
    localparam int HSCW    = BITH + 4;
    localparam int MULTBIT = (HSCW > BITJ + 1) ? HSCW : BITJ + 1;

    logic [DATASPIN-1:0][MULTBIT-1:0]    weight_ext;   // sign extended J
    logic [DATASPIN-1:0][MULTBIT-1:0]    terms;        // adder tree operands
    logic signed [MULTBIT-1:0]           hbias_ext;
    logic signed [MULTBIT-1:0]           hbias_scaled;
    logic signed [ENERGY_TOTAL_BIT-1:0]  energy_sum;
    logic                                own_spin;

    // ==============================
    // operand preparation
    // ==============================
    genvar i;
    generate
        for (i = 0; i < DATASPIN; i++) begin : g_unpack
            assign weight_ext[i] = MULTBIT'($signed(weight_i[i*BITJ +: BITJ]));
        end
    endgenerate

    assign own_spin  = |(spin_i & spin_mask_i);   // mask is one-hot
    assign hbias_ext = MULTBIT'(hbias_i);

    // h * k with k a power of two
    assign hbias_scaled = hbias_ext <<< ising_pkg::scale_shift(32'(hscaling_i));

    // J_ij * sigma_j with the bias in the diagonal slot
    always_comb begin
        for (int j = 0; j < DATASPIN; j++) begin
            if (spin_mask_i[j]) begin
                terms[j] = hbias_scaled;    // J_ii is never used
            end else if (spin_i[j]) begin
                terms[j] = weight_ext[j];
            end else begin
                terms[j] = -weight_ext[j];
            end
        end
    end

    // ==============================
    // sum and own spin sign
    // ==============================
    adder_tree #(
        .N     (DATASPIN),
        .DATAW (MULTBIT),
        .SUMW  (ENERGY_TOTAL_BIT)
    ) u_adder_tree (
        .data_i (terms),
        .sum_o  (energy_sum)
    );

    assign energy_o = own_spin ? energy_sum : -energy_sum;   // times sigma_i

endmodule

`default_nettype wire

/* src/weight_store.sv */
// ==============================
// weight_store
// flop array of the J rows and h biases
// one write port and LANES combinational row reads
// ==============================
`timescale 1ns/1ns
`default_nettype none

module weight_store #(
    parameter int BITJ     = ising_pkg::DEF_BITJ,
    parameter int BITH     = ising_pkg::DEF_BITH,
    parameter int DATASPIN = ising_pkg::DEF_DATASPIN,
    parameter int LANES    = ising_pkg::DEF_LANES,
    parameter int ROWW     = $clog2(DATASPIN)
) (
    input  logic                                  clk_i,
    input  logic                                  reset_i,
    // host write
    input  logic                                  wr_en_i,
    input  logic [ROWW-1:0]                       wr_row_i,
    input  logic [DATASPIN*BITJ-1:0]              wr_j_row_i,
    input  logic signed [BITH-1:0]                wr_h_i,
    // lane read of rows base .. base+LANES-1
    input  logic [ROWW-1:0]                       rd_base_i,
    output logic [LANES-1:0][DATASPIN*BITJ-1:0]   rd_j_o,
    output logic signed [LANES-1:0][BITH-1:0]     rd_h_o
);

    logic [DATASPIN-1:0][DATASPIN*BITJ-1:0] j_mem;   // row i = J_i*
    logic [DATASPIN-1:0][BITH-1:0]          h_mem;

    // write lands on the next cycle
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            j_mem <= '0;   // all couplings zero after reset
            h_mem <= '0;
        end else if (wr_en_i) begin
            j_mem[wr_row_i] <= wr_j_row_i;
            h_mem[wr_row_i] <= wr_h_i;
        end
    end

    // no read latency
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            rd_j_o[l] = j_mem[rd_base_i + ROWW'(l)];
            rd_h_o[l] = h_mem[rd_base_i + ROWW'(l)];
        end
    end

endmodule

`default_nettype wire

/* src/spin_dispatcher.sv */
// ==============================
// spin_dispatcher
// job handshake, spin and scale latch, group sequencing
// group outputs are registered toward the lanes
// ==============================
`timescale 1ns/1ns
`default_nettype none

module spin_dispatcher #(
    parameter int DATASPIN    = ising_pkg::DEF_DATASPIN,
    parameter int LANES       = ising_pkg::DEF_LANES,
    parameter int SCALING_BIT = ising_pkg::DEF_SCALING_BIT,
    parameter int ROWW        = $clog2(DATASPIN)
) (
    input  logic                            clk_i,
    input  logic                            reset_i,
    // job in
    input  logic                            job_valid_i,
    output logic                            job_ready_o,
    input  logic [DATASPIN-1:0]             job_spin_i,
    input  logic [SCALING_BIT-1:0]          job_scale_i,
    input  logic                            acc_busy_i,    // result still held
    // group out
    output logic [ROWW-1:0]                 grp_row_o,     // base row of group
    output logic [DATASPIN-1:0]             grp_spin_o,
    output logic [SCALING_BIT-1:0]          grp_scale_o,
    output logic [LANES-1:0][DATASPIN-1:0]  grp_mask_o,
    output logic                            grp_valid_o,
    output logic                            grp_last_o
);

    localparam int NGRP = DATASPIN / LANES;
    localparam int GRPW = (NGRP > 1) ? $clog2(NGRP) : 1;

    typedef enum logic {S_IDLE, S_RUN} state_t;

    state_t               state_q;
    logic [GRPW-1:0]      grp_cnt_q;   // next group to issue
    logic                 issue;
    logic                 job_take;

    assign job_ready_o = (state_q == S_IDLE) && !acc_busy_i;
    assign job_take    = job_valid_i && job_ready_o;
    assign issue       = (state_q == S_RUN) && !grp_last_o;   // stop once last is out

    // ==============================
    // FSM and group counter
    // ==============================
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q     <= S_IDLE;
            grp_cnt_q   <= '0;
            grp_row_o   <= '0;
            grp_valid_o <= 1'b0;
            grp_last_o  <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (job_take) begin
                        state_q   <= S_RUN;
                        grp_cnt_q <= '0;
                    end
                end
                S_RUN: begin
                    if (grp_last_o) begin
                        state_q <= S_IDLE;   // last group retired this edge
                    end
                end
                default: state_q <= S_IDLE;
            endcase

            grp_valid_o <= issue;
            grp_last_o  <= issue && (grp_cnt_q == GRPW'(NGRP - 1));
            if (issue) begin
                grp_row_o <= ROWW'(grp_cnt_q * LANES);
                grp_cnt_q <= (grp_cnt_q == GRPW'(NGRP - 1)) ? '0 : grp_cnt_q + 1'b1;
            end
        end
    end

    // job payload held for the whole run
    always_ff @(posedge clk_i) begin
        if (job_take) begin
            grp_spin_o  <= job_spin_i;
            grp_scale_o <= job_scale_i;
        end
    end

    // lane l owns spin base+l
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            grp_mask_o[l] = DATASPIN'(1) << (grp_row_o + ROWW'(l));
        end
    end

endmodule

`default_nettype wire

/* src/energy_accum.sv */
// ==============================
// energy_accum
// sums lane energies over the groups of a job and
// holds the total until the host takes it
// ==============================
`timescale 1ns/1ns
`default_nettype none

module energy_accum #(
    parameter int LANES            = ising_pkg::DEF_LANES,
    parameter int ENERGY_TOTAL_BIT = ising_pkg::DEF_ENERGY_TOTAL_BIT
) (
    input  logic                                       clk_i,
    input  logic                                       reset_i,
    input  logic signed [LANES-1:0][ENERGY_TOTAL_BIT-1:0] lane_energy_i,
    input  logic                                       grp_valid_i,
    input  logic                                       grp_last_i,
    // result out
    output logic                                       result_valid_o,
    input  logic                                       result_ready_i,
    output logic signed [ENERGY_TOTAL_BIT-1:0]         result_energy_o,
    output logic                                       acc_busy_o
);

    logic signed [ENERGY_TOTAL_BIT-1:0] lane_sum;   // all lanes of this group
    logic signed [ENERGY_TOTAL_BIT-1:0] run_sum_q;  // earlier groups of the job

    adder_tree #(
        .N     (LANES),
        .DATAW (ENERGY_TOTAL_BIT),
        .SUMW  (ENERGY_TOTAL_BIT)
    ) u_lane_sum (
        .data_i (lane_energy_i),
        .sum_o  (lane_sum)
    );

    // running sum is left at zero after each job
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            run_sum_q      <= '0;
            result_valid_o <= 1'b0;
        end else begin
            if (grp_valid_i) begin
                run_sum_q <= grp_last_i ? '0 : run_sum_q + lane_sum;
            end
            if (grp_valid_i && grp_last_i) begin
                result_valid_o <= 1'b1;
            end else if (result_ready_i) begin
                result_valid_o <= 1'b0;   // taken
            end
        end
    end

    // result register loaded with the final group folded in
    always_ff @(posedge clk_i) begin
        if (grp_valid_i && grp_last_i) begin
            result_energy_o <= run_sum_q + lane_sum;
        end
    end

    assign acc_busy_o = result_valid_o;   // blocks the next job

endmodule

`default_nettype wire

/* src/ising_energy_top.sv */
// ==============================
// ising_energy_top
// Ising energy evaluator built from weight store,
// dispatcher, lane array and accumulator
// ==============================
`timescale 1ns/1ns
`default_nettype none

module ising_energy_top #(
    parameter int BITJ             = ising_pkg::DEF_BITJ,
    parameter int BITH             = ising_pkg::DEF_BITH,
    parameter int DATASPIN         = ising_pkg::DEF_DATASPIN,
    parameter int LANES            = ising_pkg::DEF_LANES,
    parameter int SCALING_BIT      = ising_pkg::DEF_SCALING_BIT,
    parameter int ENERGY_TOTAL_BIT = ising_pkg::DEF_ENERGY_TOTAL_BIT,
    parameter int ROWW             = $clog2(DATASPIN)
) (
    input  logic                                clk_i,
    input  logic                                reset_i,
    // weight load
    input  logic                                wr_en_i,
    input  logic [ROWW-1:0]                     wr_row_i,
    input  logic [DATASPIN*BITJ-1:0]            wr_j_row_i,
    input  logic signed [BITH-1:0]              wr_h_i,
    // job
    input  logic                                job_valid_i,
    output logic                                job_ready_o,
    input  logic [DATASPIN-1:0]                 job_spin_i,
    input  logic [SCALING_BIT-1:0]              job_scale_i,
    // result
    output logic                                result_valid_o,
    input  logic                                result_ready_i,
    output logic signed [ENERGY_TOTAL_BIT-1:0]  result_energy_o
);

    logic [ROWW-1:0]                          grp_row;
    logic [DATASPIN-1:0]                      grp_spin;
    logic [SCALING_BIT-1:0]                   grp_scale;
    logic [LANES-1:0][DATASPIN-1:0]           grp_mask;
    logic                                     grp_valid;
    logic                                     grp_last;
    logic [LANES-1:0][DATASPIN*BITJ-1:0]      rd_j;
    logic signed [LANES-1:0][BITH-1:0]        rd_h;
    logic signed [LANES-1:0][ENERGY_TOTAL_BIT-1:0] lane_energy;
    logic                                     acc_busy;

    weight_store #(
        .BITJ (BITJ), .BITH (BITH), .DATASPIN (DATASPIN), .LANES (LANES), .ROWW (ROWW)
    ) u_weight_store (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .wr_en_i    (wr_en_i),
        .wr_row_i   (wr_row_i),
        .wr_j_row_i (wr_j_row_i),
        .wr_h_i     (wr_h_i),
        .rd_base_i  (grp_row),
        .rd_j_o     (rd_j),
        .rd_h_o     (rd_h)
    );

    spin_dispatcher #(
        .DATASPIN (DATASPIN), .LANES (LANES), .SCALING_BIT (SCALING_BIT), .ROWW (ROWW)
    ) u_dispatcher (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .job_valid_i (job_valid_i),
        .job_ready_o (job_ready_o),
        .job_spin_i  (job_spin_i),
        .job_scale_i (job_scale_i),
        .acc_busy_i  (acc_busy),
        .grp_row_o   (grp_row),
        .grp_spin_o  (grp_spin),
        .grp_scale_o (grp_scale),
        .grp_mask_o  (grp_mask),
        .grp_valid_o (grp_valid),
        .grp_last_o  (grp_last)
    );

    // ==============================
    // lane array with one spin per lane
    // ==============================
    genvar g;
    generate
        for (g = 0; g < LANES; g++) begin : g_lane
            partial_energy_calc #(
                .BITJ (BITJ), .BITH (BITH), .DATASPIN (DATASPIN),
                .SCALING_BIT (SCALING_BIT), .ENERGY_TOTAL_BIT (ENERGY_TOTAL_BIT)
            ) u_lane (
                .spin_i      (grp_spin),
                .spin_mask_i (grp_mask[g]),
                .weight_i    (rd_j[g]),
                .hbias_i     (rd_h[g]),
                .hscaling_i  (grp_scale),
                .energy_o    (lane_energy[g])
            );
        end
    endgenerate

    energy_accum #(
        .LANES (LANES), .ENERGY_TOTAL_BIT (ENERGY_TOTAL_BIT)
    ) u_accum (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .lane_energy_i   (lane_energy),
        .grp_valid_i     (grp_valid),
        .grp_last_i      (grp_last),
        .result_valid_o  (result_valid_o),
        .result_ready_i  (result_ready_i),
        .result_energy_o (result_energy_o),
        .acc_busy_o      (acc_busy)
    );

endmodule

`default_nettype wire

/* testbench/ising_energy_chk.sv */
// ==============================
// ising_energy_chk
// concurrent checks on the job and result handshakes
// ==============================
`timescale 1ns/1ns
`default_nettype none

module ising_energy_chk #(
    parameter int ENERGY_TOTAL_BIT = ising_pkg::DEF_ENERGY_TOTAL_BIT
) (
    input  wire logic                        clk_i,
    input  wire logic                        reset_i,
    input  wire logic                        job_ready_i,
    input  wire logic                        result_valid_i,
    input  wire logic                        result_ready_i,
    input  wire logic [ENERGY_TOTAL_BIT-1:0] result_energy_i
);

    int fail_cnt = 0;   // assertion failures so far

    // held result stays put until taken
    a_result_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        result_valid_i && !result_ready_i |=> result_valid_i && $stable(result_energy_i))
        else begin
            $error("result dropped or changed while not taken");
            fail_cnt++;
        end

    // no new job while a result waits
    a_ready_blocked: assert property (@(posedge clk_i) disable iff (reset_i)
        result_valid_i |-> !job_ready_i)
        else begin
            $error("job_ready_o high while a result is held");
            fail_cnt++;
        end

    // reset leaves no result behind
    a_reset_clear: assert property (@(posedge clk_i)
        reset_i |=> !result_valid_i)
        else begin
            $error("result_valid_o high in the cycle after reset");
            fail_cnt++;
        end

endmodule

bind ising_energy_top ising_energy_chk #(
    .ENERGY_TOTAL_BIT (ENERGY_TOTAL_BIT)
) u_chk (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .job_ready_i     (job_ready_o),
    .result_valid_i  (result_valid_o),
    .result_ready_i  (result_ready_i),
    .result_energy_i (result_energy_o)
);

`default_nettype wire

/* testbench/ising_energy_tb.sv */
// ==============================
// ising_energy_tb
// loads random J and h, runs a job table through the
// evaluator and checks energy, latency and handshakes
// ==============================
`timescale 1ns/1ns
`default_nettype none

module ising_energy_tb;

    localparam int BITJ         = ising_pkg::DEF_BITJ;
    localparam int BITH         = ising_pkg::DEF_BITH;
    localparam int DATASPIN     = ising_pkg::DEF_DATASPIN;
    localparam int LANES        = ising_pkg::DEF_LANES;
    localparam int SCALING_BIT  = ising_pkg::DEF_SCALING_BIT;
    localparam int ETB          = ising_pkg::DEF_ENERGY_TOTAL_BIT;
    localparam int ROWW         = $clog2(DATASPIN);
    localparam int NGRP         = DATASPIN / LANES;   // groups per job
    localparam int NJOBS        = 16;
    localparam int MAX_STALL    = 7;
    localparam int RESET_CYCLES = 5;
    localparam int LIMIT = RESET_CYCLES + 3*DATASPIN + NJOBS*(NGRP + MAX_STALL + 10);

    logic                        clk, reset, wr_en, job_valid, job_ready, result_valid;
    logic                        result_ready;
    logic [ROWW-1:0]             wr_row;
    logic [DATASPIN*BITJ-1:0]    wr_j_row;
    logic signed [BITH-1:0]      wr_h;
    logic [DATASPIN-1:0]         job_spin;
    logic [SCALING_BIT-1:0]      job_scale;
    logic signed [ETB-1:0]       result_energy;

    int          j_tb [DATASPIN][DATASPIN];   // model copy with row i = J_i*
    int          h_tb [DATASPIN];
    logic [15:0] lfsr_q;

    // job table
    string               t_name   [NJOBS];
    logic [DATASPIN-1:0] t_spin   [NJOBS];
    int                  t_scale  [NJOBS];
    int                  t_stall  [NJOBS];   // cycles result_ready stays low
    bit                  t_reload [NJOBS];   // rewrite some rows first
    int                  n_rows;

    ising_energy_top UUT (
        .clk_i (clk), .reset_i (reset),
        .wr_en_i (wr_en), .wr_row_i (wr_row), .wr_j_row_i (wr_j_row), .wr_h_i (wr_h),
        .job_valid_i (job_valid), .job_ready_o (job_ready),
        .job_spin_i (job_spin), .job_scale_i (job_scale),
        .result_valid_o (result_valid), .result_ready_i (result_ready),
        .result_energy_o (result_energy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period
    end

    // ==============================
    // helpers
    // ==============================
    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_q = lfsr_next(lfsr_q);   // one step per bit
            v = {v[62:0], lfsr_q[0]};
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected !== actual) begin
            abort_run($sformatf("FAILED %s: expected %0d, actual %0d", name, expected, actual));
        end
    endtask

    // sign of a spin bit
    function automatic int sigma(input logic b);
        return b ? 1 : -1;
    endfunction

    // sum_i s_i*(sum_{j!=i} J_ij*s_j + h_i*k) wrapped to the result width
    function automatic int model_energy(input logic [DATASPIN-1:0] spin, input int scale);
        int                    total;
        int                    field;
        logic signed [ETB-1:0] wrapped;
        total = 0;
        for (int i = 0; i < DATASPIN; i++) begin
            field = h_tb[i] * (1 << ising_pkg::scale_shift(scale));
            for (int j = 0; j < DATASPIN; j++) begin
                if (j != i) field += j_tb[i][j] * sigma(spin[j]);
            end
            total += sigma(spin[i]) * field;
        end
        wrapped = total[ETB-1:0];
        return int'(wrapped);
    endfunction

    // every off-diagonal J plus every h for all spins +1 at scale 1
    function automatic int offdiag_plus_bias();
        int                    total;
        logic signed [ETB-1:0] wrapped;
        total = 0;
        for (int i = 0; i < DATASPIN; i++) begin
            total += h_tb[i];
            for (int j = 0; j < DATASPIN; j++) begin
                if (j != i) total += j_tb[i][j];
            end
        end
        wrapped = total[ETB-1:0];
        return int'(wrapped);
    endfunction

    // random row r into DUT and model from a falling edge
    task automatic write_row(input int r);
        logic [63:0]              bits;
        logic [DATASPIN*BITJ-1:0] jrow;
        for (int j = 0; j < DATASPIN; j++) begin
            take_bits(BITJ, bits);
            jrow[j*BITJ +: BITJ] = bits[BITJ-1:0];
            j_tb[r][j] = $signed(bits[BITJ-1:0]);   // diagonal kept but unused
        end
        take_bits(BITH, bits);
        h_tb[r]  = $signed(bits[BITH-1:0]);
        wr_en    = 1'b1;
        wr_row   = ROWW'(r);
        wr_j_row = jrow;
        wr_h     = bits[BITH-1:0];
        @(negedge clk);
        wr_en    = 1'b0;
    endtask

    task automatic add_row(input string name, input logic [DATASPIN-1:0] spin,
                           input int scale, input int stall, input bit reload);
        t_name[n_rows]   = name;
        t_spin[n_rows]   = spin;
        t_scale[n_rows]  = scale;
        t_stall[n_rows]  = stall;
        t_reload[n_rows] = reload;
        n_rows++;
    endtask

    task automatic build_table();
        logic [63:0] r;
        add_row("all_ones", '1, 1, 0, 0);
        add_row("all_zeros", '0, 1, 0, 0);
        add_row("alternate_a", 16'hAAAA, 1, 0, 0);
        add_row("alternate_5", 16'h5555, 1, 0, 0);
        take_bits(DATASPIN, r);
        add_row("random_0", r[DATASPIN-1:0], 1, 0, 0);
        take_bits(DATASPIN, r);
        add_row("random_1", r[DATASPIN-1:0], 1, 2, 0);
        take_bits(DATASPIN, r);
        add_row("scale_2", r[DATASPIN-1:0], 2, 0, 0);
        take_bits(DATASPIN, r);
        add_row("scale_4", r[DATASPIN-1:0], 4, 0, 0);
        take_bits(DATASPIN, r);
        add_row("scale_8", r[DATASPIN-1:0], 8, 1, 0);
        take_bits(DATASPIN, r);
        add_row("scale_16", r[DATASPIN-1:0], 16, 0, 0);
        take_bits(DATASPIN, r);
        add_row("scale_0", r[DATASPIN-1:0], 0, 0, 0);
        take_bits(DATASPIN, r);
        add_row("scale_3", r[DATASPIN-1:0], 3, 0, 0);
        take_bits(DATASPIN, r);
        add_row("scale_31", r[DATASPIN-1:0], 31, 0, 0);
        take_bits(DATASPIN, r);
        add_row("stall_7", r[DATASPIN-1:0], 1, MAX_STALL, 0);
        take_bits(DATASPIN, r);
        add_row("reload_a", r[DATASPIN-1:0], 4, 0, 1);
        add_row("reload_b", '1, 16, 3, 1);
    endtask

    // ==============================
    // one table row from falling edge to falling edge
    // ==============================
    task automatic run_job(input int t);
        logic [63:0] bits;
        int          expected;
        int          cycles;
        if (t_reload[t]) begin
            for (int k = 0; k < 4; k++) begin
                take_bits(ROWW, bits);
                write_row(int'(bits[ROWW-1:0]));
            end
        end
        expected = model_energy(t_spin[t], t_scale[t]);
        check_value({t_name[t], " job_ready before job"}, 1, int'(job_ready));
        job_valid    = 1'b1;
        job_spin     = t_spin[t];
        job_scale    = SCALING_BIT'(t_scale[t]);
        result_ready = (t_stall[t] == 0);   // stalled rows hold the result
        @(negedge clk);                     // accepted on the edge just passed
        job_valid = 1'b0;
        check_value({t_name[t], " job_ready while running"}, 0, int'(job_ready));
        cycles = 0;
        while (!result_valid) begin
            @(negedge clk);
            cycles++;
        end
        check_value({t_name[t], " latency"}, NGRP + 1, cycles);
        check_value({t_name[t], " energy"}, expected, int'(result_energy));
        if (&t_spin[t] && t_scale[t] == 1) begin
            check_value({t_name[t], " direct sum"}, offdiag_plus_bias(), int'(result_energy));
        end
        for (int s = 0; s < t_stall[t]; s++) begin
            @(negedge clk);
            check_value({t_name[t], " held valid"}, 1, int'(result_valid));
            check_value({t_name[t], " held energy"}, expected, int'(result_energy));
            check_value({t_name[t], " job_ready under stall"}, 0, int'(job_ready));
        end
        result_ready = 1'b1;
        @(negedge clk);                     // taken on the edge just passed
        result_ready = 1'b0;
        check_value({t_name[t], " valid after take"}, 0, int'(result_valid));
    endtask

    // ==============================
    // main sequence
    // ==============================
    initial begin
        reset        = 1'b1;
        wr_en        = 1'b0;
        wr_row       = '0;
        wr_j_row     = '0;
        wr_h         = '0;
        job_valid    = 1'b0;
        job_spin     = '0;
        job_scale    = '0;
        result_ready = 1'b0;
        lfsr_q       = 16'd93;   // seed
        n_rows       = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_value("after_reset job_ready", 1, int'(job_ready));
        check_value("after_reset result_valid", 0, int'(result_valid));
        for (int r = 0; r < DATASPIN; r++) begin
            write_row(r);
        end
        build_table();
        for (int t = 0; t < n_rows; t++) begin
            run_job(t);
        end
        if (UUT.u_chk.fail_cnt == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            abort_run("a handshake assertion failed in the bound checker");
        end
    end

    // watchdog with a budget from the table length
    initial begin
        repeat (LIMIT) @(posedge clk);
        abort_run($sformatf("watchdog: a result never arrived within %0d cycles", LIMIT));
    end

endmodule

`default_nettype wire

/* vlog.f */
src/ising_pkg.sv
src/adder_tree.sv
src/partial_energy_calc.sv
src/weight_store.sv
src/spin_dispatcher.sv
src/energy_accum.sv
src/ising_energy_top.sv
testbench/ising_energy_chk.sv
testbench/ising_energy_tb.sv

/* Makefile */
# Verilator build and run of the Ising energy evaluator testbench

VERILATOR ?= verilator
TOP       ?= ising_energy_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard src/*.sv testbench/*.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "^PASS: all tests$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
